// File: rtl/rv32i_types_pkg.sv
// RV32I encoding types: machine word, major opcodes and immediate field widths
`default_nettype none

package rv32i_types_pkg;

    // Machine word width for RV32
    localparam int WORD_W = 32;

    // Major opcode occupies instr[6:0]
    localparam int OPCODE_W = 7;

    // B-type immediate, 12 encoded bits plus implied zero LSB
    localparam int B_IMM_W = 13;

    // J-type immediate, 20 encoded bits plus implied zero LSB
    localparam int J_IMM_W = 21;

    typedef logic [WORD_W-1:0] word_t;

    // Base opcodes of the RV32I major opcode map
    typedef enum logic [OPCODE_W-1:0] {
        // Upper immediate forms
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        // Unconditional jumps
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        // Conditional branches
        BRANCH = 7'b1100011,
        // Memory access
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        // Arithmetic, immediate and register forms
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

endpackage

`default_nettype wire

// File: rtl/fetch_cfg_pkg.sv
// Fetch configuration: reset vector, bus byte order, fault squash word, PC step
`default_nettype none

package fetch_cfg_pkg;

    // First instruction fetched out of reset
    localparam logic [31:0] RESET_PC = 32'h8000_0000;

    // Set when the instruction bus returns bytes little-endian
    localparam logic BUS_LITTLE_ENDIAN = 1'b1;

    // Word put in the instruction field on a fault or misalignment
    localparam logic [31:0] FAULT_NOP = 32'h0000_0000;

    // No compressed instructions, so always one word
    localparam logic [31:0] PC_STEP = 32'd4;

endpackage

`default_nettype wire

// File: rtl/fetch_unit.sv
// Instruction fetch unit: bus read, alignment check, fault tracking and byte swap
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  ireq,
    input  rv32i_types_pkg::word_t pc,
    input  rv32i_types_pkg::word_t bus_rdata,
    input  logic                  bus_busy,
    input  logic                  bus_error,
    output rv32i_types_pkg::word_t bus_addr,
    output logic                  bus_ren,
    output logic                  insn_ready,
    output logic                  insn_fault,
    output logic                  mal_addr,
    output rv32i_types_pkg::word_t insn_out,
    output rv32i_types_pkg::word_t insn_addr
);
    import rv32i_types_pkg::*;
    import fetch_cfg_pkg::*;

    logic  access_done;
    logic  access_err;
    logic  err_pend;
    word_t err_addr;

    // Word alignment only, no compressed support
    assign mal_addr = (pc[1:0] != 2'b00);

    // Misaligned PC never reaches the bus
    assign bus_ren  = ireq && !mal_addr;
    assign bus_addr = pc;

    // Access ends on first non-busy cycle with ren high
    assign access_done = bus_ren && !bus_busy;
    assign access_err  = access_done && bus_error;

    // Misalignment completes at once
    assign insn_ready = mal_addr || access_done;

    // Error seen earlier in this access stays visible until PC moves
    assign insn_fault = access_err || (err_pend && (err_addr == pc));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            err_pend <= 1'b0;
        end else if (access_err) begin
            err_pend <= 1'b1;
        end else if (err_pend && (err_addr != pc)) begin
            // PC left the faulting address
            err_pend <= 1'b0;
        end
    end

    // Address of the faulting access
    always_ff @(posedge CLK) begin
        if (access_err) begin
            err_addr <= pc;
        end
    end

    // Bus data to instruction order
    always_comb begin
        if (BUS_LITTLE_ENDIAN) begin
            insn_out = {bus_rdata[7:0], bus_rdata[15:8],
                        bus_rdata[23:16], bus_rdata[31:24]};
        end else begin
            insn_out = bus_rdata;
        end
    end

    // Physical address of this fetch, for fault reporting
    assign insn_addr = pc;

endmodule

`default_nettype wire

// File: rtl/static_predictor.sv
// Static branch predictor: backward branches and JAL taken, target is PC plus immediate
`timescale 1ns/100ps
`default_nettype none

module static_predictor (
    input  rv32i_types_pkg::word_t instr,
    input  rv32i_types_pkg::word_t pc,
    output logic                  predict_taken,
    output rv32i_types_pkg::word_t target_addr
);
    import rv32i_types_pkg::*;

    opcode_t              opcode;
    logic [B_IMM_W-1:0]   imm_b;
    logic [J_IMM_W-1:0]   imm_j;
    word_t                imm_b_ext;
    word_t                imm_j_ext;

    // Major opcode field
    assign opcode = opcode_t'(instr[OPCODE_W-1:0]);

    // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign imm_b = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // J-type: imm[20|10:1|11|19:12] in 31:12
    assign imm_j = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Sign extension to a full word
    assign imm_b_ext = {{(WORD_W-B_IMM_W){imm_b[B_IMM_W-1]}}, imm_b};
    assign imm_j_ext = {{(WORD_W-J_IMM_W){imm_j[J_IMM_W-1]}}, imm_j};

    always_comb begin
        case (opcode)
            // Always taken, target known from the encoding
            JAL:     predict_taken = 1'b1;
            // Backward means loop, negative offset
            BRANCH:  predict_taken = imm_b[B_IMM_W-1];
            // Register target unknown in fetch
            JALR:    predict_taken = 1'b0;
            default: predict_taken = 1'b0;
        endcase
    end

    // JAL uses the J immediate, everything else the B immediate
    assign target_addr = pc + ((opcode == JAL) ? imm_j_ext : imm_b_ext);

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
// Fetch stage: PC register, next-PC priority select and fetch/execute pipeline register
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  logic                   CLK,
    input  logic                   nRST,
    // Hazard controls
    input  logic                   pc_en,
    input  logic                   iren,
    input  logic                   suppress_iren,
    input  logic                   if_ex_stall,
    input  logic                   if_ex_flush,
    input  logic                   insert_priv_pc,
    input  rv32i_types_pkg::word_t priv_pc,
    input  logic                   rollback,
    input  rv32i_types_pkg::word_t rollback_pc,
    input  logic                   npc_sel,
    input  rv32i_types_pkg::word_t brj_addr,
    input  logic                   prot_fault_i,
    // Predictor return
    input  logic                   predict_taken,
    input  rv32i_types_pkg::word_t target_addr,
    // Instruction bus
    input  rv32i_types_pkg::word_t bus_rdata,
    input  logic                   bus_busy,
    input  logic                   bus_error,
    output rv32i_types_pkg::word_t bus_addr,
    output logic                   bus_ren,
    // Status
    output logic                   i_mem_busy,
    output rv32i_types_pkg::word_t pc_f,
    output rv32i_types_pkg::word_t fault_addr,
    output rv32i_types_pkg::word_t fetched_instr,
    // Fetch/execute register
    output logic                   ex_valid,
    output rv32i_types_pkg::word_t ex_instr,
    output rv32i_types_pkg::word_t ex_pc,
    output rv32i_types_pkg::word_t ex_pc4,
    output logic                   ex_prediction,
    output rv32i_types_pkg::word_t ex_predicted_address,
    output logic                   ex_mal_insn,
    output logic                   ex_fault_insn,
    output rv32i_types_pkg::word_t ex_fault_addr
);
    import rv32i_types_pkg::*;
    import fetch_cfg_pkg::*;

    word_t pc;
    word_t pc4;
    word_t npc;
    word_t insn_out;
    word_t insn_addr;
    logic  ireq;
    logic  insn_ready;
    logic  bus_fault;
    logic  mal_addr;
    logic  fault_insn;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= npc;
        end
    end

    assign pc4 = pc + PC_STEP;

    // Privileged redirect wins, then rollback, branch, prediction
    always_comb begin
        if (insert_priv_pc)     npc = priv_pc;
        else if (rollback)      npc = rollback_pc;
        else if (npc_sel)       npc = brj_addr;
        else if (predict_taken) npc = target_addr;
        else                    npc = pc4;
    end

    assign ireq = iren && !suppress_iren;

    fetch_unit FETCHER (
        .CLK,
        .nRST,
        .ireq,
        .pc,
        .bus_rdata,
        .bus_busy,
        .bus_error,
        .bus_addr,
        .bus_ren,
        .insn_ready,
        .insn_fault(bus_fault),
        .mal_addr,
        .insn_out,
        .insn_addr
    );

    // Protection and bus faults share one flag
    assign fault_insn = prot_fault_i || bus_fault;

    // Squashed word also keeps the predictor quiet
    assign fetched_instr = (fault_insn || mal_addr) ? FAULT_NOP : insn_out;

    assign i_mem_busy = !insn_ready && !fault_insn;
    assign pc_f       = pc;
    assign fault_addr = insn_addr;

    // Flush only takes effect when not stalled
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_valid             <= 1'b0;
            ex_instr             <= '0;
            ex_pc                <= '0;
            ex_pc4               <= '0;
            ex_prediction        <= 1'b0;
            ex_predicted_address <= '0;
            ex_mal_insn          <= 1'b0;
            ex_fault_insn        <= 1'b0;
            ex_fault_addr        <= '0;
        end else if (!if_ex_stall) begin
            if (if_ex_flush) begin
                ex_valid             <= 1'b0;
                ex_instr             <= '0;
                ex_pc                <= '0;
                ex_pc4               <= '0;
                ex_prediction        <= 1'b0;
                ex_predicted_address <= '0;
                ex_mal_insn          <= 1'b0;
                ex_fault_insn        <= 1'b0;
                ex_fault_addr        <= '0;
            end else begin
                // Faulted fetch still valid so execute can trap
                ex_valid             <= 1'b1;
                ex_instr             <= fetched_instr;
                ex_pc                <= pc;
                ex_pc4               <= pc4;
                ex_prediction        <= predict_taken;
                ex_predicted_address <= target_addr;
                ex_mal_insn          <= mal_addr;
                ex_fault_insn        <= fault_insn;
                ex_fault_addr        <= fault_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
// Fetch front end top: fetch stage plus static predictor, wired to the core ports
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                   CLK,
    input  logic                   nRST,
    // Hazard controls
    input  logic                   pc_en,
    input  logic                   iren,
    input  logic                   suppress_iren,
    input  logic                   if_ex_stall,
    input  logic                   if_ex_flush,
    input  logic                   insert_priv_pc,
    input  rv32i_types_pkg::word_t priv_pc,
    input  logic                   rollback,
    input  rv32i_types_pkg::word_t rollback_pc,
    input  logic                   npc_sel,
    input  rv32i_types_pkg::word_t brj_addr,
    input  logic                   prot_fault_i,
    // Instruction bus
    input  rv32i_types_pkg::word_t bus_rdata,
    input  logic                   bus_busy,
    input  logic                   bus_error,
    output rv32i_types_pkg::word_t bus_addr,
    output logic                   bus_ren,
    // Status
    output logic                   i_mem_busy,
    output rv32i_types_pkg::word_t pc_f,
    output rv32i_types_pkg::word_t fault_addr,
    // Fetch/execute register
    output logic                   ex_valid,
    output rv32i_types_pkg::word_t ex_instr,
    output rv32i_types_pkg::word_t ex_pc,
    output rv32i_types_pkg::word_t ex_pc4,
    output logic                   ex_prediction,
    output rv32i_types_pkg::word_t ex_predicted_address,
    output logic                   ex_mal_insn,
    output logic                   ex_fault_insn,
    output rv32i_types_pkg::word_t ex_fault_addr
);
    import rv32i_types_pkg::*;

    // Predictor loop, combinational
    word_t fetched_instr;
    word_t target_addr;
    logic  predict_taken;

    fetch_stage STAGE (
        .CLK, .nRST,
        .pc_en, .iren, .suppress_iren, .if_ex_stall, .if_ex_flush,
        .insert_priv_pc, .priv_pc, .rollback, .rollback_pc,
        .npc_sel, .brj_addr, .prot_fault_i,
        .predict_taken, .target_addr,
        .bus_rdata, .bus_busy, .bus_error, .bus_addr, .bus_ren,
        .i_mem_busy, .pc_f, .fault_addr, .fetched_instr,
        .ex_valid, .ex_instr, .ex_pc, .ex_pc4, .ex_prediction,
        .ex_predicted_address, .ex_mal_insn, .ex_fault_insn, .ex_fault_addr
    );

    // Predicts on the current PC and the word fetched there
    static_predictor PREDICTOR (
        .instr(fetched_instr),
        .pc(pc_f),
        .predict_taken,
        .target_addr
    );

endmodule

`default_nettype wire

// File: tests/fetch_assert.sv
// Fetch stage assertions: bus alignment, PC hold, flush clear and busy versus fault
`timescale 1ns/100ps
`default_nettype none

module fetch_assert (
    input logic                   CLK,
    input logic                   nRST,
    input logic                   pc_en,
    input rv32i_types_pkg::word_t pc,
    input logic                   bus_ren,
    input rv32i_types_pkg::word_t bus_addr,
    input logic                   if_ex_stall,
    input logic                   if_ex_flush,
    input logic                   ex_valid,
    input logic                   i_mem_busy,
    input logic                   prot_fault_i,
    input logic                   bus_busy,
    input logic                   bus_error
);
    // Failure count, watched from the testbench top
    int unsigned fails = 0;

    // Misaligned PC never reaches the bus
    ren_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        bus_ren |-> (bus_addr[1:0] == 2'b00))
    else begin
        $error("bus read issued at misaligned address %h", bus_addr);
        fails = fails + 1;
    end

    // PC frozen while the hazard unit holds it
    pc_hold: assert property (@(posedge CLK) disable iff (!nRST)
        !pc_en |=> (pc == $past(pc)))
    else begin
        $error("PC moved with pc_en low");
        fails = fails + 1;
    end

    // Flush clears only when not stalled
    flush_clear: assert property (@(posedge CLK) disable iff (!nRST)
        (if_ex_flush && !if_ex_stall) |=> !ex_valid)
    else begin
        $error("ex_valid still set after flush");
        fails = fails + 1;
    end

    // Protection fault or bus error at access end releases the wait
    busy_vs_fault: assert property (@(posedge CLK) disable iff (!nRST)
        (prot_fault_i || (bus_ren && !bus_busy && bus_error)) |-> !i_mem_busy)
    else begin
        $error("i_mem_busy high during a fetch fault");
        fails = fails + 1;
    end

endmodule

`default_nettype wire

// File: tests/fetch_tb.sv
// Fetch front end testbench: memory model, hazard model and table-driven checks
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;
    import rv32i_types_pkg::*;
    import fetch_cfg_pkg::*;

    localparam int N_ROWS       = 24;
    localparam int RESET_CYCLES = 3;
    // Up to 3 busy cycles plus ending and check edges, rounded up
    localparam int ROW_CYCLES   = 8;
    // Reset, all rows, and idle slack
    localparam int MAX_CYCLES   = RESET_CYCLES + N_ROWS * ROW_CYCLES + 55;
    localparam int unsigned SEED = 9326;

    // Instruction words used by the program
    localparam word_t ADDI  = 32'h00108093;
    localparam word_t NOP   = 32'h00000013;
    localparam word_t BBACK = 32'hFE000CE3;  // beq x0,x0,-8
    localparam word_t BFWD  = 32'h00000463;  // beq x0,x0,+8
    localparam word_t JFWD  = 32'h0100006F;  // jal x0,+16
    localparam word_t JR    = 32'h00008067;  // jalr x0,0(x1)

    // Offsets are from RESET_PC
    typedef struct packed {
        logic [2:0]  redir;   // priv, rollback, npc_sel
        logic [31:0] priv_off;
        logic [31:0] rb_off;
        logic [31:0] brj_off;
        word_t       word;
        logic [1:0]  flt;     // 1 memory error, 2 protection fault
        logic [1:0]  sf;      // forced stall, flush
        logic [31:0] pc_off;
        word_t       instr;
        logic [2:0]  pmf;     // prediction, misaligned, fault
        logic [31:0] tgt_off;
    } row_t;

    // redir priv rb brj | word flt sf | fetch pc, expected instr, pmf, target
    localparam row_t TABLE [N_ROWS] = '{
        '{3'b000, 'h0,   'h0,   'h0,   ADDI,  2'd0, 2'b00, 'h0,   ADDI,      3'b000, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   NOP,   2'd0, 2'b00, 'h4,   NOP,       3'b000, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   ADDI,  2'd0, 2'b00, 'h8,   ADDI,      3'b000, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   BBACK, 2'd0, 2'b00, 'hC,   BBACK,     3'b100, 'h4},
        '{3'b000, 'h0,   'h0,   'h0,   BFWD,  2'd0, 2'b00, 'h4,   BFWD,      3'b000, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   JFWD,  2'd0, 2'b00, 'h8,   JFWD,      3'b100, 'h18},
        '{3'b000, 'h0,   'h0,   'h0,   JR,    2'd0, 2'b00, 'h18,  JR,        3'b000, 'h0},
        '{3'b001, 'h0,   'h0,   'h100, ADDI,  2'd0, 2'b00, 'h1C,  ADDI,      3'b000, 'h0},
        '{3'b011, 'h0,   'h200, 'h300, NOP,   2'd0, 2'b00, 'h100, NOP,       3'b000, 'h0},
        '{3'b111, 'h400, 'h500, 'h600, NOP,   2'd0, 2'b00, 'h200, NOP,       3'b000, 'h0},
        '{3'b001, 'h0,   'h0,   'h480, BBACK, 2'd0, 2'b00, 'h400, BBACK,     3'b100, 'h3F8},
        '{3'b100, 'h40,  'h0,   'h0,   JFWD,  2'd0, 2'b00, 'h480, JFWD,      3'b100, 'h490},
        '{3'b001, 'h0,   'h0,   'h42,  ADDI,  2'd0, 2'b00, 'h40,  ADDI,      3'b000, 'h0},
        '{3'b001, 'h0,   'h0,   'h60,  NOP,   2'd0, 2'b00, 'h42,  FAULT_NOP, 3'b010, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   ADDI,  2'd1, 2'b00, 'h60,  FAULT_NOP, 3'b001, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   NOP,   2'd2, 2'b00, 'h64,  FAULT_NOP, 3'b001, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   BBACK, 2'd2, 2'b00, 'h68,  FAULT_NOP, 3'b001, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   ADDI,  2'd0, 2'b00, 'h6C,  ADDI,      3'b000, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   NOP,   2'd0, 2'b10, 'h70,  NOP,       3'b000, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   ADDI,  2'd0, 2'b00, 'h74,  ADDI,      3'b000, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   NOP,   2'd0, 2'b01, 'h78,  NOP,       3'b000, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   BBACK, 2'd0, 2'b00, 'h7C,  BBACK,     3'b100, 'h74},
        '{3'b000, 'h0,   'h0,   'h0,   NOP,   2'd0, 2'b11, 'h74,  NOP,       3'b000, 'h0},
        '{3'b000, 'h0,   'h0,   'h0,   ADDI,  2'd0, 2'b00, 'h78,  ADDI,      3'b000, 'h0}
    };

    logic  CLK = 1'b0;
    logic  nRST, pc_en, iren, suppress_iren, if_ex_stall, if_ex_flush, force_stall;
    logic  insert_priv_pc, rollback, npc_sel, prot_fault_i, bus_busy, bus_error, bus_ren;
    logic  i_mem_busy, ex_valid, ex_prediction, ex_mal_insn, ex_fault_insn;
    word_t priv_pc, rollback_pc, brj_addr, bus_rdata, bus_addr, pc_f, fault_addr;
    word_t ex_instr, ex_pc, ex_pc4, ex_predicted_address, ex_fault_addr;

    // Bus-order memory image and per-address error flags
    word_t       mem [word_t];
    bit          err_map [word_t];
    int unsigned lcg_state = SEED;
    int          cycles = 0;

    // Expected fetch/execute register contents
    logic  e_valid, e_pred, e_mal, e_fault;
    word_t e_pc, e_instr, e_tgt;

    // Hazard model
    assign pc_en       = !i_mem_busy;
    assign if_ex_stall = i_mem_busy || force_stall;

    fetch_top DUT (.*);

    bind fetch_stage fetch_assert ASSERTS (
        .CLK, .nRST, .pc_en, .pc, .bus_ren, .bus_addr, .if_ex_stall,
        .if_ex_flush, .ex_valid, .i_mem_busy, .prot_fault_i, .bus_busy, .bus_error
    );

    always #4 CLK = ~CLK;

    // Watchdog, also picks up bound assertion failures
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Verification failed");
            $fatal(1, "Simulation timed out after %0d cycles", cycles);
        end else if (DUT.STAGE.ASSERTS.fails != 0) begin
            $display("Verification failed");
            $fatal(1, "Concurrent assertion failed in the fetch stage");
        end
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 1103515245 + 12345;
        return lcg_state >> 16;
    endfunction

    // Little-endian bus word to instruction order
    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t exp);
        assert (got === exp)
        else begin
            $display("[ERROR] %0t %s is %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic check_ex();
        check_value("ex_valid", 32'(ex_valid), 32'(e_valid));
        check_value("ex_pc", ex_pc, e_pc);
        check_value("ex_pc4", ex_pc4, e_valid ? e_pc + PC_STEP : '0);
        check_value("ex_instr", ex_instr, e_instr);
        check_value("ex_prediction", 32'(ex_prediction), 32'(e_pred));
        // Target only meaningful when taken
        if (e_pred) begin
            check_value("ex_predicted_address", ex_predicted_address, e_tgt);
        end
        check_value("ex_mal_insn", 32'(ex_mal_insn), 32'(e_mal));
        check_value("ex_fault_insn", 32'(ex_fault_insn), 32'(e_fault));
        check_value("ex_fault_addr", ex_fault_addr, e_pc);
    endtask

    initial begin
        row_t        row;
        word_t       fetch_pc;
        int unsigned rnd;
        int          busy_left;
        nRST = 1'b0;
        iren = 1'b0;
        suppress_iren = 1'b0;
        if_ex_flush = 1'b0;
        force_stall = 1'b0;
        insert_priv_pc = 1'b0;
        rollback = 1'b0;
        npc_sel = 1'b0;
        prot_fault_i = 1'b0;
        priv_pc = '0;
        rollback_pc = '0;
        brj_addr = '0;
        bus_rdata = '0;
        // Memory idles busy so nothing completes before the first row
        bus_busy = 1'b1;
        bus_error = 1'b0;
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;
        iren = 1'b1;
        @(negedge CLK);
        check_value("pc_f after reset", pc_f, RESET_PC);
        check_value("ex_valid after reset", 32'(ex_valid), 32'd0);

        for (int i = 0; i < N_ROWS; i++) begin
            row = TABLE[i];
            fetch_pc = RESET_PC + row.pc_off;
            // Bus side settled since the last rising edge
            check_value("pc_f", pc_f, fetch_pc);
            check_value("fault_addr", fault_addr, fetch_pc);
            check_value("bus_ren", 32'(bus_ren), 32'(!row.pmf[1]));
            if (!row.pmf[1]) begin
                check_value("bus_addr", bus_addr, fetch_pc);
            end

            insert_priv_pc = row.redir[2];
            priv_pc = RESET_PC + row.priv_off;
            rollback = row.redir[1];
            rollback_pc = RESET_PC + row.rb_off;
            npc_sel = row.redir[0];
            brj_addr = RESET_PC + row.brj_off;
            prot_fault_i = (row.flt == 2'd2);
            force_stall = row.sf[1];
            if_ex_flush = row.sf[0];

            // Memory responds at the bus address
            mem[fetch_pc] = swap_bytes(row.word);
            err_map[fetch_pc] = (row.flt == 2'd1);
            bus_rdata = mem.exists(bus_addr) ? mem[bus_addr] : '0;
            bus_error = err_map.exists(bus_addr) ? err_map[bus_addr] : 1'b0;

            // No wait states when the fetch ends without a bus handshake
            rnd = next_rand();
            busy_left = (row.pmf[1] || prot_fault_i) ? 0 : rnd % 4;
            bus_busy = (busy_left != 0);
            while (busy_left != 0) begin
                @(negedge CLK);
                // Read still pending with the memory busy
                check_value("i_mem_busy", 32'(i_mem_busy), 32'd1);
                busy_left = busy_left - 1;
                bus_busy = (busy_left != 0);
            end
            @(negedge CLK);

            // Register load rule, stall wins over flush
            if (!row.sf[1]) begin
                e_valid = !row.sf[0];
                e_pc    = row.sf[0] ? '0 : fetch_pc;
                e_instr = row.sf[0] ? '0 : row.instr;
                e_pred  = !row.sf[0] && row.pmf[2];
                e_tgt   = RESET_PC + row.tgt_off;
                e_mal   = !row.sf[0] && row.pmf[1];
                e_fault = !row.sf[0] && row.pmf[0];
            end
            check_ex();
        end

        if (DUT.STAGE.ASSERTS.fails == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "Concurrent assertion failures in the fetch stage");
        end
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/rv32i_types_pkg.sv
rtl/fetch_cfg_pkg.sv
rtl/fetch_unit.sv
rtl/static_predictor.sv
rtl/fetch_stage.sv
rtl/fetch_top.sv
tests/fetch_assert.sv
tests/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the fetch testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module fetch_tb -Mdir obj_dir -f sim.f
	./obj_dir/Vfetch_tb +verilator+error+limit+100

clean:
	rm -rf obj_dir
